// ==== hdl/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    localparam int ID_W   = 4;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int LEN_W  = 8;
    localparam int STRB_W = 4;

    localparam logic [ADDR_W-1:0] SLAVE_BASE_ADDR = 32'h1000_0000;

    // word offsets from the base
    localparam logic [ADDR_W-1:0] REG_STATUS    = 32'd0;
    localparam logic [ADDR_W-1:0] REG_SHIFT_OUT = 32'd1;
    localparam logic [ADDR_W-1:0] REG_SHIFT_IN  = 32'd2;
    localparam logic [ADDR_W-1:0] REG_SHIFT_CMD = 32'd3;

    localparam logic [1:0] BURST_FIXED = 2'd0;
    localparam logic [1:0] BURST_INCR  = 2'd1;
    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    localparam logic [DATA_W-1:0] ERR_READ_DATA = '1;

endpackage

`default_nettype wire

// ==== hdl/bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_ctrl (
    input  logic                        clk,
    input  logic                        jtag_rstn_sync,
    input  logic [axi_pkg::ID_W-1:0]    wr_addr_id,
    input  logic [axi_pkg::ADDR_W-1:0]  wr_addr,
    input  logic [axi_pkg::LEN_W-1:0]   wr_addr_len,
    input  logic [1:0]                  wr_addr_burst,
    input  logic                        wr_addr_valid,
    output logic                        wr_addr_ready,
    input  logic [axi_pkg::DATA_W-1:0]  wr_data,
    input  logic [axi_pkg::STRB_W-1:0]  wr_strb,
    input  logic                        wr_data_last,
    input  logic                        wr_data_valid,
    output logic                        wr_data_ready,
    output logic [axi_pkg::ID_W-1:0]    wr_back_id,
    output logic [1:0]                  wr_back_resp,
    output logic                        wr_back_valid,
    input  logic                        wr_back_ready,
    input  logic [axi_pkg::ID_W-1:0]    rd_addr_id,
    input  logic [axi_pkg::ADDR_W-1:0]  rd_addr,
    input  logic [axi_pkg::LEN_W-1:0]   rd_addr_len,
    input  logic [1:0]                  rd_addr_burst,
    input  logic                        rd_addr_valid,
    output logic                        rd_addr_ready,
    output logic [axi_pkg::ID_W-1:0]    rd_back_id,
    output logic [axi_pkg::DATA_W-1:0]  rd_data,
    output logic [1:0]                  rd_data_resp,
    output logic                        rd_data_last,
    output logic                        rd_data_valid,
    input  logic                        rd_data_ready,
    input  logic                        engine_idle,
    output logic                        clr_cmd,
    output logic                        clr_in,
    output logic                        clr_out,
    fifo_if.producer                    cmd_fifo,
    fifo_if.producer                    in_fifo,
    fifo_if.consumer                    out_fifo
);

    localparam logic [1:0] WR_IDLE = 2'd0;
    localparam logic [1:0] WR_DATA = 2'd1;
    localparam logic [1:0] WR_RESP = 2'd2;

    logic [1:0]                 wr_state;
    logic [axi_pkg::ID_W-1:0]   wr_id;
    logic [1:0]                 wr_burst;
    logic [axi_pkg::LEN_W-1:0]  wr_len;
    logic [axi_pkg::LEN_W-1:0]  wr_cnt;
    logic [axi_pkg::ADDR_W-1:0] wr_off;
    logic                       wr_err;     // sticky over the burst
    logic                       wr_beat_err;
    logic                       wr_fire;
    logic                       status_wr;
    logic                       rd_busy;
    logic [axi_pkg::ID_W-1:0]   rd_id;
    logic [1:0]                 rd_burst;
    logic [axi_pkg::LEN_W-1:0]  rd_len;
    logic [axi_pkg::LEN_W-1:0]  rd_cnt;
    logic [axi_pkg::ADDR_W-1:0] rd_off;
    logic                       rd_beat_err;
    logic                       rd_fire;
    logic [axi_pkg::DATA_W-1:0] status_word;

    // a write LAST that misses beat LEN also errs
    assign wr_beat_err = !(wr_burst == axi_pkg::BURST_FIXED || wr_burst == axi_pkg::BURST_INCR)
                      || !(wr_off == axi_pkg::REG_STATUS || wr_off == axi_pkg::REG_SHIFT_IN
                           || wr_off == axi_pkg::REG_SHIFT_CMD)
                      || (wr_data_last != (wr_cnt == wr_len));
    assign wr_addr_ready = (wr_state == WR_IDLE);
    assign wr_data_ready = (wr_state == WR_DATA) && (wr_beat_err
                         || (wr_off == axi_pkg::REG_SHIFT_IN  ? !in_fifo.full  :
                             wr_off == axi_pkg::REG_SHIFT_CMD ? !cmd_fifo.full : 1'b1));
    assign wr_fire        = wr_data_valid && wr_data_ready;
    assign wr_back_valid  = (wr_state == WR_RESP);
    assign wr_back_resp   = wr_err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
    assign wr_back_id     = wr_id;
    assign status_wr      = wr_fire && !wr_beat_err && (wr_off == axi_pkg::REG_STATUS);
    assign in_fifo.push   = wr_fire && !wr_beat_err && (wr_off == axi_pkg::REG_SHIFT_IN);
    assign cmd_fifo.push  = wr_fire && !wr_beat_err && (wr_off == axi_pkg::REG_SHIFT_CMD);
    assign in_fifo.push_data  = wr_data;
    assign cmd_fifo.push_data = wr_data;

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            wr_state <= WR_IDLE;
            wr_err   <= 1'b0;
            wr_cnt   <= '0;
        end else begin
            case (wr_state)
                WR_IDLE: if (wr_addr_valid) begin
                    wr_state <= WR_DATA;
                    wr_err   <= 1'b0;
                    wr_cnt   <= '0;
                end
                WR_DATA: if (wr_fire) begin
                    wr_err <= wr_err || wr_beat_err;
                    wr_cnt <= wr_cnt + 1'b1;
                    if (wr_data_last)
                        wr_state <= WR_RESP;
                end
                WR_RESP: if (wr_back_ready)
                    wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_addr_valid && wr_addr_ready) begin
            wr_id    <= wr_addr_id;
            wr_burst <= wr_addr_burst;
            wr_len   <= wr_addr_len;
            wr_off   <= wr_addr - axi_pkg::SLAVE_BASE_ADDR;
        end else if (wr_fire && wr_burst == axi_pkg::BURST_INCR) begin
            wr_off <= wr_off + 1'b1;
        end
    end

    // read channel
    assign rd_beat_err = !(rd_burst == axi_pkg::BURST_FIXED || rd_burst == axi_pkg::BURST_INCR)
                      || !(rd_off == axi_pkg::REG_STATUS || rd_off == axi_pkg::REG_SHIFT_OUT);
    assign rd_addr_ready = !rd_busy;
    assign rd_data_valid = rd_busy
                        && (rd_beat_err || rd_off == axi_pkg::REG_STATUS || !out_fifo.empty);
    assign rd_data_last  = rd_data_valid && (rd_cnt == rd_len);
    assign rd_data_resp  = rd_beat_err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
    assign rd_back_id    = rd_id;
    assign rd_data       = rd_beat_err                  ? axi_pkg::ERR_READ_DATA :
                           rd_off == axi_pkg::REG_STATUS ? status_word : out_fifo.pop_data;
    assign rd_fire       = rd_data_valid && rd_data_ready;
    assign out_fifo.pop  = rd_fire && !rd_beat_err && (rd_off == axi_pkg::REG_SHIFT_OUT);

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            rd_busy <= 1'b0;
            rd_cnt  <= '0;
        end else if (!rd_busy) begin
            rd_busy <= rd_addr_valid;
            rd_cnt  <= '0;
        end else if (rd_fire) begin
            rd_cnt <= rd_cnt + 1'b1;
            if (rd_data_last)
                rd_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_addr_valid && rd_addr_ready) begin
            rd_id    <= rd_addr_id;
            rd_burst <= rd_addr_burst;
            rd_len   <= rd_addr_len;
            rd_off   <= rd_addr - axi_pkg::SLAVE_BASE_ADDR;
        end else if (rd_fire && rd_burst == axi_pkg::BURST_INCR) begin
            rd_off <= rd_off + 1'b1;
        end
    end

    // flush bits live for one cycle only
    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            clr_out <= 1'b0;
            clr_in  <= 1'b0;
            clr_cmd <= 1'b0;
        end else begin
            clr_out <= status_wr && wr_strb[jtag_pkg::ST_OUT_CLR/8] && wr_data[jtag_pkg::ST_OUT_CLR];
            clr_in  <= status_wr && wr_strb[jtag_pkg::ST_IN_CLR/8] && wr_data[jtag_pkg::ST_IN_CLR];
            clr_cmd <= status_wr && wr_strb[jtag_pkg::ST_CMD_CLR/8] && wr_data[jtag_pkg::ST_CMD_CLR];
        end
    end

    always_comb begin
        status_word = '0;
        status_word[jtag_pkg::ST_OUT_CLR]   = clr_out;
        status_word[jtag_pkg::ST_OUT_EMPTY] = out_fifo.empty;
        status_word[jtag_pkg::ST_OUT_FULL]  = out_fifo.full;
        status_word[jtag_pkg::ST_IN_CLR]    = clr_in;
        status_word[jtag_pkg::ST_IN_EMPTY]  = in_fifo.empty;
        status_word[jtag_pkg::ST_IN_FULL]   = in_fifo.full;
        status_word[jtag_pkg::ST_CMD_CLR]   = clr_cmd;
        status_word[jtag_pkg::ST_CMD_EMPTY] = cmd_fifo.empty;
        status_word[jtag_pkg::ST_CMD_FULL]  = cmd_fifo.full;
        status_word[jtag_pkg::ST_CMD_DONE]  = cmd_fifo.empty && engine_idle;
    end

    assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        wr_back_valid && !wr_back_ready |=> wr_back_valid && $stable(wr_back_resp));
    assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        rd_data_valid && !rd_data_ready
        |=> rd_data_valid && $stable(rd_data_last) && $stable(rd_data_resp));

endmodule

`default_nettype wire

// ==== hdl/fifo_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fifo_if;

    logic                       push;
    logic [axi_pkg::DATA_W-1:0] push_data;
    logic                       pop;
    logic [axi_pkg::DATA_W-1:0] pop_data;   // head word, valid while not empty
    logic                       empty;
    logic                       full;

    modport producer (output push, output push_data, input full, input empty);
    modport consumer (output pop, input pop_data, input empty, input full);
    modport storage (
        input  push, input  push_data, input  pop,
        output pop_data, output empty, output full
    );

endinterface

`default_nettype wire

// ==== hdl/jtag_axi_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_axi_slave (
    input  logic                        clk,
    input  logic                        jtag_rstn_sync,
    output logic                        tck,
    output logic                        tms,
    output logic                        tdi,
    input  logic                        tdo,
    input  logic [axi_pkg::ID_W-1:0]    wr_addr_id,
    input  logic [axi_pkg::ADDR_W-1:0]  wr_addr,
    input  logic [axi_pkg::LEN_W-1:0]   wr_addr_len,
    input  logic [1:0]                  wr_addr_burst,
    input  logic                        wr_addr_valid,
    output logic                        wr_addr_ready,
    input  logic [axi_pkg::DATA_W-1:0]  wr_data,
    input  logic [axi_pkg::STRB_W-1:0]  wr_strb,
    input  logic                        wr_data_last,
    input  logic                        wr_data_valid,
    output logic                        wr_data_ready,
    output logic [axi_pkg::ID_W-1:0]    wr_back_id,
    output logic [1:0]                  wr_back_resp,
    output logic                        wr_back_valid,
    input  logic                        wr_back_ready,
    input  logic [axi_pkg::ID_W-1:0]    rd_addr_id,
    input  logic [axi_pkg::ADDR_W-1:0]  rd_addr,
    input  logic [axi_pkg::LEN_W-1:0]   rd_addr_len,
    input  logic [1:0]                  rd_addr_burst,
    input  logic                        rd_addr_valid,
    output logic                        rd_addr_ready,
    output logic [axi_pkg::ID_W-1:0]    rd_back_id,
    output logic [axi_pkg::DATA_W-1:0]  rd_data,
    output logic [1:0]                  rd_data_resp,
    output logic                        rd_data_last,
    output logic                        rd_data_valid,
    input  logic                        rd_data_ready
);

    logic clr_cmd;
    logic clr_in;
    logic clr_out;
    logic engine_idle;

    fifo_if cmd_fifo ();
    fifo_if in_fifo ();
    fifo_if out_fifo ();

    word_fifo #(.DEPTH(jtag_pkg::CMD_DEPTH)) u_cmd_fifo (
        .clk, .jtag_rstn_sync, .clr(clr_cmd), .fifo(cmd_fifo.storage)
    );
    word_fifo #(.DEPTH(jtag_pkg::DATA_DEPTH)) u_in_fifo (
        .clk, .jtag_rstn_sync, .clr(clr_in), .fifo(in_fifo.storage)
    );
    word_fifo #(.DEPTH(jtag_pkg::DATA_DEPTH)) u_out_fifo (
        .clk, .jtag_rstn_sync, .clr(clr_out), .fifo(out_fifo.storage)
    );

    bus_ctrl u_bus_ctrl (
        .clk, .jtag_rstn_sync,
        .wr_addr_id, .wr_addr, .wr_addr_len, .wr_addr_burst, .wr_addr_valid, .wr_addr_ready,
        .wr_data, .wr_strb, .wr_data_last, .wr_data_valid, .wr_data_ready,
        .wr_back_id, .wr_back_resp, .wr_back_valid, .wr_back_ready,
        .rd_addr_id, .rd_addr, .rd_addr_len, .rd_addr_burst, .rd_addr_valid, .rd_addr_ready,
        .rd_back_id, .rd_data, .rd_data_resp, .rd_data_last, .rd_data_valid, .rd_data_ready,
        .engine_idle, .clr_cmd, .clr_in, .clr_out,
        .cmd_fifo(cmd_fifo.producer), .in_fifo(in_fifo.producer), .out_fifo(out_fifo.consumer)
    );

    shift_engine u_shift_engine (
        .clk, .jtag_rstn_sync, .tdo, .tck, .tms, .tdi, .engine_idle,
        .cmd_fifo(cmd_fifo.consumer), .in_fifo(in_fifo.consumer), .out_fifo(out_fifo.producer)
    );

endmodule

`default_nettype wire

// ==== hdl/jtag_pkg.sv ====
`default_nettype none

package jtag_pkg;

    // command word is {cmd, cycles}
    localparam int CMD_W   = 4;
    localparam int CYCLE_W = 28;

    localparam logic [CMD_W-1:0] CMD_TMS_HIGH = 4'd1;
    localparam logic [CMD_W-1:0] CMD_TMS_LOW  = 4'd2;
    localparam logic [CMD_W-1:0] CMD_SHIFT    = 4'd3;

    localparam int CMD_DEPTH  = 8;
    localparam int DATA_DEPTH = 16;

    // status register layout, one byte per fifo
    localparam int ST_OUT_CLR   = 0;
    localparam int ST_OUT_EMPTY = 1;
    localparam int ST_OUT_FULL  = 2;
    localparam int ST_IN_CLR    = 8;
    localparam int ST_IN_EMPTY  = 9;
    localparam int ST_IN_FULL   = 10;
    localparam int ST_CMD_CLR   = 16;
    localparam int ST_CMD_EMPTY = 17;
    localparam int ST_CMD_FULL  = 18;
    localparam int ST_CMD_DONE  = 24;

endpackage

`default_nettype wire

// ==== hdl/shift_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_engine (
    input  logic      clk,
    input  logic      jtag_rstn_sync,
    input  logic      tdo,
    output logic      tck,
    output logic      tms,
    output logic      tdi,
    output logic      engine_idle,
    fifo_if.consumer  cmd_fifo,
    fifo_if.consumer  in_fifo,
    fifo_if.producer  out_fifo
);

    logic                                busy;
    logic                                armed;    // tms/tdi ready for next rise
    logic [jtag_pkg::CMD_W-1:0]          cmd_q;
    logic [jtag_pkg::CYCLE_W-1:0]        cnt;      // cycles left incl. current
    logic [$clog2(axi_pkg::DATA_W)-1:0]  bit_idx;
    logic [$clog2(axi_pkg::DATA_W)-1:0]  pres_idx;
    logic [axi_pkg::DATA_W-1:0]          out_word;
    logic [jtag_pkg::CMD_W-1:0]          new_cmd;
    logic [jtag_pkg::CYCLE_W-1:0]        new_cycles;
    logic                                new_ok;
    logic                                is_shift;
    logic                                word_end;
    logic                                pres_last;
    logic                                data_ok;
    logic                                present;
    logic                                rise;

    assign new_cmd    = cmd_fifo.pop_data[axi_pkg::DATA_W-1 -: jtag_pkg::CMD_W];
    assign new_cycles = cmd_fifo.pop_data[jtag_pkg::CYCLE_W-1:0];
    assign new_ok     = (new_cmd == jtag_pkg::CMD_TMS_HIGH || new_cmd == jtag_pkg::CMD_TMS_LOW
                         || new_cmd == jtag_pkg::CMD_SHIFT) && (new_cycles != '0);
    assign cmd_fifo.pop = !busy && !cmd_fifo.empty;   // bad commands dropped here
    assign engine_idle  = !busy;

    assign is_shift  = (cmd_q == jtag_pkg::CMD_SHIFT);
    assign word_end  = (bit_idx == '1) || (cnt == 1);
    // while tck is high the bit after the current one gets set up
    assign pres_idx  = tck ? bit_idx + 1'b1 : bit_idx;
    assign pres_last = tck ? (cnt == 2) : (cnt == 1);
    assign data_ok   = !is_shift || !in_fifo.empty;
    assign present   = busy && (tck ? (cnt != 1) : !armed) && data_ok;
    assign rise      = busy && !tck && armed && !(is_shift && word_end && out_fifo.full);

    // word done on this rise, tdo goes straight into the pushed word
    assign in_fifo.pop        = rise && is_shift && word_end && !in_fifo.empty;
    assign out_fifo.push      = rise && is_shift && word_end;
    assign out_fifo.push_data = out_word | ({{(axi_pkg::DATA_W-1){1'b0}}, tdo} << bit_idx);

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            busy    <= 1'b0;
            armed   <= 1'b0;
            tck     <= 1'b0;
            tms     <= 1'b0;
            tdi     <= 1'b0;
            cmd_q   <= '0;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            if (!busy) begin
                if (cmd_fifo.pop && new_ok) begin
                    busy    <= 1'b1;
                    armed   <= 1'b0;
                    cmd_q   <= new_cmd;
                    cnt     <= new_cycles;
                    bit_idx <= '0;
                end
            end else if (tck) begin
                tck   <= 1'b0;             // falling edge
                armed <= present;
                if (cnt == 1) begin
                    busy <= 1'b0;
                end else begin
                    cnt     <= cnt - 1'b1;
                    bit_idx <= pres_idx;
                end
            end else if (present) begin
                armed <= 1'b1;             // waited for in_fifo data
            end else if (rise) begin
                tck <= 1'b1;
            end
            if (present) begin
                tms <= is_shift ? pres_last : (cmd_q == jtag_pkg::CMD_TMS_HIGH);
                tdi <= is_shift && in_fifo.pop_data[pres_idx];
            end
        end
    end

    // captured bits, cleared between words
    always_ff @(posedge clk) begin
        if (!busy || out_fifo.push)
            out_word <= '0;
        else if (rise)
            out_word[bit_idx] <= tdo;
    end

    assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        engine_idle |=> $stable(tck));

endmodule

`default_nettype wire

// ==== hdl/word_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
    parameter int DEPTH = 16
) (
    input  logic    clk,
    input  logic    jtag_rstn_sync,
    input  logic    clr,             // flush pulse
    fifo_if.storage fifo
);

    logic [axi_pkg::DATA_W-1:0] mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH):0]     count;
    logic                       do_push;
    logic                       do_pop;

    assign do_push       = fifo.push && !fifo.full;
    assign do_pop        = fifo.pop && !fifo.empty;
    assign fifo.empty    = (count == '0);
    assign fifo.full     = (count == DEPTH);
    assign fifo.pop_data = mem[rd_ptr];    // fall-through head

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= fifo.push_data;
    end

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + do_push - do_pop;
        end
    end

    // both sides of the fifo must honour the flags
    assert property (@(posedge clk) disable iff (!jtag_rstn_sync) fifo.push |-> !fifo.full);
    assert property (@(posedge clk) disable iff (!jtag_rstn_sync) fifo.pop |-> !fifo.empty);

endmodule

`default_nettype wire

// ==== jtag_axi_slave.f ====
hdl/axi_pkg.sv
hdl/jtag_pkg.sv
hdl/fifo_if.sv
hdl/word_fifo.sv
hdl/bus_ctrl.sv
hdl/shift_engine.sv
hdl/jtag_axi_slave.sv
sim/tb_jtag_axi_slave.sv

// ==== sim/tb_jtag_axi_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_jtag_axi_slave;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int SHIFT_BITS   = 70 + 5 + 3;
    localparam int BUS_XFERS    = 80;    // transactions incl. status polls
    localparam int LIMIT_CYCLES = RESET_CYCLES + SHIFT_BITS * 8 + BUS_XFERS * 12;
    localparam logic [31:0] BASE = axi_pkg::SLAVE_BASE_ADDR;

    logic        clk = 1'b0;
    logic        jtag_rstn_sync;
    logic        tck;
    logic        tms;
    logic        tdi;
    logic        tdo = 1'b0;
    logic [3:0]  wr_addr_id;
    logic [31:0] wr_addr;
    logic [7:0]  wr_addr_len;
    logic [1:0]  wr_addr_burst;
    logic        wr_addr_valid;
    logic        wr_addr_ready;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic        wr_data_last;
    logic        wr_data_valid;
    logic        wr_data_ready;
    logic [3:0]  wr_back_id;
    logic [1:0]  wr_back_resp;
    logic        wr_back_valid;
    logic        wr_back_ready;
    logic [3:0]  rd_addr_id;
    logic [31:0] rd_addr;
    logic [7:0]  rd_addr_len;
    logic [1:0]  rd_addr_burst;
    logic        rd_addr_valid;
    logic        rd_addr_ready;
    logic [3:0]  rd_back_id;
    logic [31:0] rd_data;
    logic [1:0]  rd_data_resp;
    logic        rd_data_last;
    logic        rd_data_valid;
    logic        rd_data_ready;

    logic [31:0] lfsr = 32'h8233d6be;
    logic [31:0] wr_words[$];            // beats of the next write burst
    logic [31:0] rd_words[$];
    logic [1:0]  rd_resps[$];
    int          tck_rises = 0;
    int          tck_rises_tms = 0;

    jtag_axi_slave UUT (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // tdi returns on tdo half a clock later
    always @(negedge clk) begin
        tdo <= tdi;
    end

    always @(posedge tck) begin
        tck_rises++;
        if (tms)
            tck_rises_tms++;
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not complete within %0d cycles", LIMIT_CYCLES);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
            $display("TB FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output logic [31:0] w);
        int i;
        w = '0;
        for (i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] status_bits(input logic out_empty, input logic in_empty,
                                                input logic cmd_empty, input logic done);
        logic [31:0] s;
        s = '0;
        s[jtag_pkg::ST_OUT_EMPTY] = out_empty;
        s[jtag_pkg::ST_IN_EMPTY]  = in_empty;
        s[jtag_pkg::ST_CMD_EMPTY] = cmd_empty;
        s[jtag_pkg::ST_CMD_DONE]  = done;
        return s;
    endfunction

    task automatic bus_write(input logic [3:0] id, input logic [31:0] word, input int len,
                             input logic [1:0] burst, input logic [3:0] strb,
                             output logic [1:0] resp);
        int beat;
        @(negedge clk);
        wr_addr_id    = id;
        wr_addr       = BASE + word;
        wr_addr_len   = len;
        wr_addr_burst = burst;
        wr_addr_valid = 1'b1;
        #1;
        while (!wr_addr_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        wr_addr_valid = 1'b0;
        for (beat = 0; beat <= len; beat++) begin
            wr_data       = wr_words[beat];
            wr_strb       = strb;
            wr_data_last  = (beat == len);
            wr_data_valid = 1'b1;
            #1;
            while (!wr_data_ready) begin    // full fifo stalls the beat
                @(negedge clk);
                #1;
            end
            @(negedge clk);
        end
        wr_data_valid = 1'b0;
        wr_data_last  = 1'b0;
        wr_back_ready = 1'b1;
        #1;
        while (!wr_back_valid) begin
            @(negedge clk);
            #1;
        end
        check_eq(wr_back_id, id, "write response id");
        resp = wr_back_resp;
        @(negedge clk);
        wr_back_ready = 1'b0;
    endtask

    // stall holds ready low that many cycles before the second beat
    task automatic bus_read(input logic [3:0] id, input logic [31:0] word, input int len,
                            input logic [1:0] burst, input int stall);
        int          beat;
        logic [31:0] held;
        rd_words.delete();
        rd_resps.delete();
        @(negedge clk);
        rd_addr_id    = id;
        rd_addr       = BASE + word;
        rd_addr_len   = len;
        rd_addr_burst = burst;
        rd_addr_valid = 1'b1;
        #1;
        while (!rd_addr_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        rd_addr_valid = 1'b0;
        for (beat = 0; beat <= len; beat++) begin
            if (beat == 1 && stall > 0) begin
                rd_data_ready = 1'b0;
                #1;
                while (!rd_data_valid) begin
                    @(negedge clk);
                    #1;
                end
                held = rd_data;
                repeat (stall) begin
                    @(negedge clk);
                    #1;
                    check_eq(rd_data_valid, 1'b1, "read valid held under back-pressure");
                    check_eq(rd_data, held, "read data held under back-pressure");
                end
                @(negedge clk);
            end
            rd_data_ready = 1'b1;
            #1;
            while (!rd_data_valid) begin
                @(negedge clk);
                #1;
            end
            check_eq(rd_back_id, id, "read id");
            check_eq(rd_data_last, beat == len, "read last flag");
            rd_words.push_back(rd_data);
            rd_resps.push_back(rd_data_resp);
            @(negedge clk);
        end
        rd_data_ready = 1'b0;
    endtask

    task automatic send_cmd(input logic [3:0] cmd, input int cycles);
        logic [1:0] resp;
        wr_words.delete();
        wr_words.push_back({cmd, cycles[jtag_pkg::CYCLE_W-1:0]});
        bus_write(4'h3, axi_pkg::REG_SHIFT_CMD, 0, axi_pkg::BURST_FIXED, 4'hF, resp);
        check_eq(resp, axi_pkg::RESP_OKAY, "command write response");
    endtask

    task automatic wait_cmd_done();
        logic done;
        done = 1'b0;
        while (!done) begin
            bus_read(4'h0, axi_pkg::REG_STATUS, 0, axi_pkg::BURST_FIXED, 0);
            done = rd_words[0][jtag_pkg::ST_CMD_DONE];
        end
    endtask

    task automatic check_reset_state();
        check_eq(wr_addr_ready, 1'b1, "write address ready after reset");
        check_eq(rd_addr_ready, 1'b1, "read address ready after reset");
        check_eq({wr_back_valid, rd_data_valid, tck, tms, tdi}, '0, "outputs low after reset");
        bus_read(4'h1, axi_pkg::REG_STATUS, 0, axi_pkg::BURST_FIXED, 0);
        check_eq(rd_words[0], status_bits(1'b1, 1'b1, 1'b1, 1'b1), "status after reset");
        check_eq(rd_resps[0], axi_pkg::RESP_OKAY, "status read response");
    endtask

    task automatic check_error_responses();
        logic [1:0] resp;
        int         i;
        bus_read(4'h2, axi_pkg::REG_SHIFT_IN, 0, axi_pkg::BURST_INCR, 0);
        check_eq(rd_resps[0], axi_pkg::RESP_SLVERR, "read of word 2");
        check_eq(rd_words[0], axi_pkg::ERR_READ_DATA, "error read data");
        bus_read(4'h2, 32'd5, 0, axi_pkg::BURST_INCR, 0);
        check_eq(rd_resps[0], axi_pkg::RESP_SLVERR, "read of offset 5");
        bus_read(4'h2, axi_pkg::REG_STATUS, 0, 2'd2, 0);
        check_eq(rd_resps[0], axi_pkg::RESP_SLVERR, "read with burst code 2");
        check_eq(rd_words[0], axi_pkg::ERR_READ_DATA, "error read data, bad burst");
        wr_words.delete();
        wr_words.push_back(32'h0);
        bus_write(4'h5, axi_pkg::REG_SHIFT_OUT, 0, axi_pkg::BURST_FIXED, 4'hF, resp);
        check_eq(resp, axi_pkg::RESP_SLVERR, "write of word 1");
        bus_write(4'h5, 32'd5, 0, axi_pkg::BURST_FIXED, 4'hF, resp);
        check_eq(resp, axi_pkg::RESP_SLVERR, "write of offset 5");
        bus_write(4'h5, axi_pkg::REG_STATUS, 0, 2'd2, 4'hF, resp);
        check_eq(resp, axi_pkg::RESP_SLVERR, "write with burst code 2");
        bus_read(4'hA, axi_pkg::REG_STATUS, 3, axi_pkg::BURST_FIXED, 0);   // id and last per beat
        check_eq({rd_addr_ready, rd_data_valid}, 2'b10, "read channel idle after burst");
        for (i = 0; i < 4; i++)
            check_eq(rd_resps[i], axi_pkg::RESP_OKAY, "status burst response");
    endtask

    task automatic run_data_shift();
        logic [31:0] sent[3];
        logic [1:0]  resp;
        int          i;
        wr_words.delete();
        for (i = 0; i < 3; i++) begin
            random_word(sent[i]);
            wr_words.push_back(sent[i]);
        end
        bus_write(4'h6, axi_pkg::REG_SHIFT_IN, 2, axi_pkg::BURST_FIXED, 4'hF, resp);
        check_eq(resp, axi_pkg::RESP_OKAY, "tdi burst write response");
        send_cmd(jtag_pkg::CMD_SHIFT, 70);
        wait_cmd_done();
        for (i = 0; i < 3; i++) begin
            bus_read(4'h7, axi_pkg::REG_SHIFT_OUT, 0, axi_pkg::BURST_FIXED, 0);
            check_eq(rd_resps[0], axi_pkg::RESP_OKAY, "tdo word read response");
            // 70 bits leave 6 in the last word
            check_eq(rd_words[0], (i == 2) ? (sent[i] & 32'h3F) : sent[i], "captured tdo word");
        end
    endtask

    task automatic run_tms_command(input logic [3:0] cmd, input int cycles, input int high);
        int rises;
        int rises_high;
        @(negedge clk);
        rises      = tck_rises;
        rises_high = tck_rises_tms;
        send_cmd(cmd, cycles);
        wait_cmd_done();
        check_eq(tck_rises - rises, cycles, "tck rising edges");
        check_eq(tck_rises_tms - rises_high, high, "tck edges with tms high");
    endtask

    task automatic run_flush();
        logic [1:0]  resp;
        logic [31:0] w;
        int          i;
        wr_words.delete();
        for (i = 0; i < 4; i++) begin
            random_word(w);
            wr_words.push_back(w);
        end
        bus_write(4'h8, axi_pkg::REG_SHIFT_IN, 3, axi_pkg::BURST_FIXED, 4'hF, resp);
        check_eq(resp, axi_pkg::RESP_OKAY, "fill write response");
        bus_read(4'h8, axi_pkg::REG_STATUS, 0, axi_pkg::BURST_FIXED, 0);
        check_eq(rd_words[0], status_bits(1'b1, 1'b0, 1'b1, 1'b1), "status with tdi words");
        wr_words.delete();
        wr_words.push_back(32'h1 << jtag_pkg::ST_IN_CLR);
        bus_write(4'h9, axi_pkg::REG_STATUS, 0, axi_pkg::BURST_FIXED, 4'b0010, resp);
        check_eq(resp, axi_pkg::RESP_OKAY, "flush write response");
        bus_read(4'h9, axi_pkg::REG_STATUS, 0, axi_pkg::BURST_FIXED, 0);
        check_eq(rd_words[0], status_bits(1'b1, 1'b1, 1'b1, 1'b1), "status after flush");
    endtask

    task automatic run_read_backpressure();
        int i;
        bus_read(4'hC, axi_pkg::REG_STATUS, 3, axi_pkg::BURST_FIXED, 5);
        check_eq({rd_addr_ready, rd_data_valid}, 2'b10, "read channel idle after stalled burst");
        for (i = 0; i < 4; i++)
            check_eq(rd_words[i], status_bits(1'b1, 1'b1, 1'b1, 1'b1), "stalled status beat");
    endtask

    initial begin
        jtag_rstn_sync = 1'b0;
        wr_addr_id     = '0;
        wr_addr        = '0;
        wr_addr_len    = '0;
        wr_addr_burst  = '0;
        wr_addr_valid  = 1'b0;
        wr_data        = '0;
        wr_strb        = '0;
        wr_data_last   = 1'b0;
        wr_data_valid  = 1'b0;
        wr_back_ready  = 1'b0;
        rd_addr_id     = '0;
        rd_addr        = '0;
        rd_addr_len    = '0;
        rd_addr_burst  = '0;
        rd_addr_valid  = 1'b0;
        rd_data_ready  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        jtag_rstn_sync = 1'b1;

        check_reset_state();
        check_error_responses();
        run_data_shift();
        run_tms_command(jtag_pkg::CMD_TMS_HIGH, 5, 5);
        run_tms_command(jtag_pkg::CMD_TMS_LOW, 3, 0);
        run_flush();
        run_read_backpressure();

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
